//--- Makefile
TOP := tb_sw_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- flist.f
+incdir+logic
+incdir+testbench
logic/sw_pkg.sv
logic/sw_pe.sv
logic/sw_array.sv
logic/sw_row_max.sv
logic/sw_best_select.sv
logic/sw_ctrl.sv
logic/sw_core.sv
testbench/tb_sw_core.sv

//--- logic/sw_array.sv
// systolic PE chain with the delayed score registers between rows
`timescale 1ns/1ps
`default_nettype none

`include "sw_config.svh"

module sw_array (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 i_clear,
    input  wire                                 i_a_valid,
    input  wire sw_pkg::base_t                  i_a_base,
    input  wire sw_pkg::col_t                   i_a_col,
    input  wire [`SW_READ_MAX_LENGTH-1:0]       i_b_valid,
    input  wire sw_pkg::read_seq_t              i_read,
    output wire [`SW_READ_MAX_LENGTH-1:0]       o_cell_valid,
    output wire sw_pkg::score_t                 o_h [`SW_READ_MAX_LENGTH],
    output wire sw_pkg::col_t                   o_col [`SW_READ_MAX_LENGTH]
);
    import sw_pkg::*;

    score_t i_out [`SW_READ_MAX_LENGTH];
    score_t d_out [`SW_READ_MAX_LENGTH];

    // one cycle back is the left cell, two cycles back the diagonal
    score_t h_q1 [`SW_READ_MAX_LENGTH];
    score_t i_q1 [`SW_READ_MAX_LENGTH];
    score_t d_q1 [`SW_READ_MAX_LENGTH];
    score_t h_q2 [`SW_READ_MAX_LENGTH];

    logic  a_valid_c [`SW_READ_MAX_LENGTH+1];
    base_t a_base_c  [`SW_READ_MAX_LENGTH+1];
    col_t  a_col_c   [`SW_READ_MAX_LENGTH+1];

    assign a_valid_c[0] = i_a_valid;
    assign a_base_c[0]  = i_a_base;
    assign a_col_c[0]   = i_a_col;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < `SW_READ_MAX_LENGTH; r++) begin
                h_q1[r] <= '0;
                i_q1[r] <= '0;
                d_q1[r] <= '0;
                h_q2[r] <= '0;
            end
        end else if (i_clear) begin
            for (int r = 0; r < `SW_READ_MAX_LENGTH; r++) begin
                h_q1[r] <= '0;
                i_q1[r] <= '0;
                d_q1[r] <= '0;
                h_q2[r] <= '0;
            end
        end else begin
            for (int r = 0; r < `SW_READ_MAX_LENGTH; r++) begin
                h_q1[r] <= o_h[r];
                i_q1[r] <= i_out[r];
                d_q1[r] <= d_out[r];
                h_q2[r] <= h_q1[r];
            end
        end
    end

    for (genvar r = 0; r < `SW_READ_MAX_LENGTH; r++) begin : g_pe
        score_t h_top, i_top, h_diag;

        if (r == 0) begin : g_first
            assign h_top  = '0;  // row above the matrix
            assign i_top  = '0;
            assign h_diag = '0;
        end else begin : g_next
            assign h_top  = h_q1[r-1];
            assign i_top  = i_q1[r-1];
            assign h_diag = h_q2[r-1];
        end

        sw_pe u_pe (
            .clk          (clk),
            .rst          (rst),
            .i_clear      (i_clear),
            .i_a_valid    (a_valid_c[r]),
            .i_a_base     (a_base_c[r]),
            .i_a_col      (a_col_c[r]),
            .i_b_valid    (i_b_valid[r]),
            .i_b_base     (i_read[2*`SW_READ_MAX_LENGTH-1-2*r -: 2]),
            .i_h_diag     (h_diag),
            .i_h_top      (h_top),
            .i_i_top      (i_top),
            .i_h_left     (h_q1[r]),
            .i_d_left     (d_q1[r]),
            .o_h          (o_h[r]),
            .o_i          (i_out[r]),
            .o_d          (d_out[r]),
            .o_cell_valid (o_cell_valid[r]),
            .o_a_valid    (a_valid_c[r+1]),
            .o_a_base     (a_base_c[r+1]),
            .o_a_col      (a_col_c[r+1])
        );

        assign o_col[r] = a_col_c[r];  // column now inside PE r
    end

endmodule

`default_nettype wire

//--- logic/sw_best_select.sv
// row-by-row scan keeping the best score with its row and column
`timescale 1ns/1ps
`default_nettype none

module sw_best_select (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 i_clear,
    input  wire                 i_select,
    input  wire sw_pkg::row_t   i_sel_row,
    input  wire sw_pkg::score_t i_row_score,
    input  wire sw_pkg::col_t   i_row_col,
    output sw_pkg::score_t      o_score,
    output sw_pkg::row_t        o_row,
    output sw_pkg::col_t        o_col
);
    import sw_pkg::*;

    score_t best_q;
    row_t   row_q;
    col_t   col_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            best_q <= '0;
            row_q  <= '0;
            col_q  <= '0;
        end else if (i_clear) begin
            best_q <= '0;
            row_q  <= '0;
            col_q  <= '0;
        end else if (i_select && (i_row_score > best_q)) begin
            // rows come in ascending order, so ties stay on the lower row
            best_q <= i_row_score;
            row_q  <= i_sel_row;
            col_q  <= i_row_col;
        end
    end

    assign o_score = best_q;
    assign o_row   = row_q;
    assign o_col   = col_q;

endmodule

`default_nettype wire

//--- logic/sw_config.svh
// sizing and scoring macros for the smith-waterman engine
`ifndef SW_CONFIG_SVH
`define SW_CONFIG_SVH

// sequence capacity
`define SW_REF_MAX_LENGTH   16
`define SW_READ_MAX_LENGTH  8   // one PE per read base

// signed score width, wide enough for a full-length match run
`define SW_SCORE_BITWIDTH   10

// substitution scores
`define SW_MATCH_SCORE      2
`define SW_MISMATCH_SCORE   (-1)

// affine gap penalties
`define SW_GAP_OPEN         (-3)
`define SW_GAP_EXTEND       (-1)

`endif

//--- logic/sw_core.sv
// top level: controller, PE array, row maxima and final selector
`timescale 1ns/1ps
`default_nettype none

`include "sw_config.svh"

module sw_core (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     i_valid,
    output wire                     o_ready,
    input  wire sw_pkg::ref_seq_t   i_sequence_ref,
    input  wire sw_pkg::read_seq_t  i_sequence_read,
    input  wire sw_pkg::ref_len_t   i_ref_length,
    input  wire sw_pkg::read_len_t  i_read_length,
    input  wire                     i_ready,
    output wire                     o_valid,
    output wire sw_pkg::score_t     o_alignment_score,
    output wire sw_pkg::row_t       o_row,
    output wire sw_pkg::col_t       o_column
);
    import sw_pkg::*;

    logic                           clear;
    logic                           a_valid;
    base_t                          a_base;
    col_t                           a_col;
    logic [`SW_READ_MAX_LENGTH-1:0] b_valid;
    read_seq_t                      read;
    logic                           select;
    row_t                           sel_row;
    wire [`SW_READ_MAX_LENGTH-1:0]  cell_valid;
    wire score_t                    h [`SW_READ_MAX_LENGTH];
    wire col_t                      col [`SW_READ_MAX_LENGTH];
    score_t                         row_score;
    col_t                           row_col;

    sw_ctrl u_ctrl (
        .clk(clk), .rst(rst), .i_valid(i_valid), .i_sequence_ref(i_sequence_ref),
        .i_sequence_read(i_sequence_read), .i_ref_length(i_ref_length),
        .i_read_length(i_read_length), .i_ready(i_ready), .o_ready(o_ready),
        .o_valid(o_valid), .o_clear(clear), .o_a_valid(a_valid), .o_a_base(a_base),
        .o_a_col(a_col), .o_b_valid(b_valid), .o_read(read), .o_select(select),
        .o_sel_row(sel_row)
    );

    sw_array u_array (
        .clk(clk), .rst(rst), .i_clear(clear), .i_a_valid(a_valid), .i_a_base(a_base),
        .i_a_col(a_col), .i_b_valid(b_valid), .i_read(read),
        .o_cell_valid(cell_valid), .o_h(h), .o_col(col)
    );

    sw_row_max u_row_max (
        .clk(clk), .rst(rst), .i_clear(clear), .i_cell_valid(cell_valid), .i_h(h),
        .i_col(col), .i_sel_row(sel_row), .o_row_score(row_score), .o_row_col(row_col)
    );

    sw_best_select u_best (
        .clk(clk), .rst(rst), .i_clear(clear), .i_select(select), .i_sel_row(sel_row),
        .i_row_score(row_score), .i_row_col(row_col),
        .o_score(o_alignment_score), .o_row(o_row), .o_col(o_column)
    );

endmodule

`default_nettype wire

//--- logic/sw_ctrl.sv
// job FSM, phase counter, sequence latch, reference shifter and handshake
`timescale 1ns/1ps
`default_nettype none

`include "sw_config.svh"

module sw_ctrl (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             i_valid,
    input  wire sw_pkg::ref_seq_t           i_sequence_ref,
    input  wire sw_pkg::read_seq_t          i_sequence_read,
    input  wire sw_pkg::ref_len_t           i_ref_length,
    input  wire sw_pkg::read_len_t          i_read_length,
    input  wire                             i_ready,
    output logic                            o_ready,
    output logic                            o_valid,
    output logic                            o_clear,
    output logic                            o_a_valid,
    output sw_pkg::base_t                   o_a_base,
    output sw_pkg::col_t                    o_a_col,
    output logic [`SW_READ_MAX_LENGTH-1:0]  o_b_valid,
    output sw_pkg::read_seq_t               o_read,
    output logic                            o_select,
    output sw_pkg::row_t                    o_sel_row
);
    import sw_pkg::*;

    typedef logic [$clog2(`SW_REF_MAX_LENGTH + `SW_READ_MAX_LENGTH)-1:0] cnt_t;

    sw_state_t state, state_n;
    cnt_t      counter;
    ref_len_t  ref_len;
    read_len_t read_len;
    ref_seq_t  ref_shift;
    read_seq_t read_q;
    logic      accept, calc_last, select_last;

    assign accept      = (state == S_IDLE) && i_valid;
    assign calc_last   = (counter == cnt_t'(ref_len) + cnt_t'(read_len) - cnt_t'(1));
    assign select_last = (counter == cnt_t'(read_len) - cnt_t'(1));

    always_comb begin
        state_n = state;
        case (state)
            S_IDLE:   if (i_valid) state_n = S_LOAD;
            S_LOAD:   state_n = S_CALC;
            S_CALC:   if (calc_last) state_n = S_SELECT;
            S_SELECT: if (select_last) state_n = S_DONE;
            S_DONE:   if (i_ready) state_n = S_IDLE;  // held under back-pressure
            default:  state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            counter   <= '0;
            o_b_valid <= '0;
        end else begin
            state <= state_n;
            if ((state == S_CALC && !calc_last) || (state == S_SELECT && !select_last))
                counter <= counter + cnt_t'(1);
            else
                counter <= '0;
            if (accept) begin
                for (int r = 0; r < `SW_READ_MAX_LENGTH; r++)
                    o_b_valid[r] <= (read_len_t'(r) < i_read_length);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ref_shift <= i_sequence_ref;
            read_q    <= i_sequence_read;
            ref_len   <= i_ref_length;
            read_len  <= i_read_length;
        end else if (state == S_CALC) begin
            ref_shift <= ref_shift << 2;  // next base to the top
        end
    end

    assign o_ready   = (state == S_IDLE);
    assign o_valid   = (state == S_DONE);
    assign o_clear   = accept;
    assign o_a_valid = (state == S_CALC) && (counter < cnt_t'(ref_len));
    assign o_a_base  = ref_shift[2*`SW_REF_MAX_LENGTH-1 -: 2];
    assign o_a_col   = col_t'(counter);
    assign o_read    = read_q;
    assign o_select  = (state == S_SELECT);
    assign o_sel_row = row_t'(counter);

endmodule

`default_nettype wire

//--- logic/sw_pe.sv
// processing element: affine-gap H/I/D cell and reference base pipeline stage
`timescale 1ns/1ps
`default_nettype none

`include "sw_config.svh"

module sw_pe (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 i_clear,
    input  wire                 i_a_valid,
    input  wire sw_pkg::base_t  i_a_base,
    input  wire sw_pkg::col_t   i_a_col,
    input  wire                 i_b_valid,
    input  wire sw_pkg::base_t  i_b_base,
    input  wire sw_pkg::score_t i_h_diag,
    input  wire sw_pkg::score_t i_h_top,
    input  wire sw_pkg::score_t i_i_top,
    input  wire sw_pkg::score_t i_h_left,
    input  wire sw_pkg::score_t i_d_left,
    output sw_pkg::score_t      o_h,
    output sw_pkg::score_t      o_i,
    output sw_pkg::score_t      o_d,
    output logic                o_cell_valid,
    output logic                o_a_valid,
    output sw_pkg::base_t       o_a_base,
    output sw_pkg::col_t        o_a_col
);
    import sw_pkg::*;

    score_t sub;
    score_t i_new, d_new, h_new;
    score_t h_q, i_q, d_q;  // last valid cell

    function automatic score_t max3(input score_t a, input score_t b, input score_t c);
        score_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    assign o_cell_valid = i_a_valid && i_b_valid;

    assign sub = (i_a_base == i_b_base) ? score_t'(`SW_MATCH_SCORE)
                                        : score_t'(`SW_MISMATCH_SCORE);

    assign i_new = max3('0, i_h_top + score_t'(`SW_GAP_OPEN), i_i_top + score_t'(`SW_GAP_EXTEND));
    assign d_new = max3('0, i_h_left + score_t'(`SW_GAP_OPEN),
                        i_d_left + score_t'(`SW_GAP_EXTEND));
    // I and D are already floored, so H never drops below zero
    assign h_new = max3(i_h_diag + sub, i_new, d_new);

    assign o_h = o_cell_valid ? h_new : h_q;
    assign o_i = o_cell_valid ? i_new : i_q;
    assign o_d = o_cell_valid ? d_new : d_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_q       <= '0;
            i_q       <= '0;
            d_q       <= '0;
            o_a_valid <= 1'b0;
        end else begin
            if (i_clear) begin
                h_q <= '0;
                i_q <= '0;
                d_q <= '0;
            end else if (o_cell_valid) begin
                h_q <= h_new;
                i_q <= i_new;
                d_q <= d_new;
            end
            o_a_valid <= i_a_valid;
        end
    end

    // reference base moves one PE per cycle
    always_ff @(posedge clk) begin
        o_a_base <= i_a_base;
        o_a_col  <= i_a_col;
    end

endmodule

`default_nettype wire

//--- logic/sw_pkg.sv
// score, base, index, length, sequence and controller state types
`default_nettype none

`include "sw_config.svh"

package sw_pkg;

    typedef logic signed [`SW_SCORE_BITWIDTH-1:0] score_t;
    typedef logic [1:0] base_t;  // one nucleotide

    typedef logic [$clog2(`SW_REF_MAX_LENGTH)-1:0] col_t;
    typedef logic [$clog2(`SW_READ_MAX_LENGTH)-1:0] row_t;

    // 1-based lengths
    typedef logic [$clog2(`SW_REF_MAX_LENGTH):0] ref_len_t;
    typedef logic [$clog2(`SW_READ_MAX_LENGTH):0] read_len_t;

    // first base in the top two bits
    typedef logic [2*`SW_REF_MAX_LENGTH-1:0] ref_seq_t;
    typedef logic [2*`SW_READ_MAX_LENGTH-1:0] read_seq_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_CALC,
        S_SELECT,
        S_DONE
    } sw_state_t;

endpackage

`default_nettype wire

//--- logic/sw_row_max.sv
// per-row running maximum H and its column, with row readout
`timescale 1ns/1ps
`default_nettype none

`include "sw_config.svh"

module sw_row_max (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             i_clear,
    input  wire [`SW_READ_MAX_LENGTH-1:0]   i_cell_valid,
    input  wire sw_pkg::score_t             i_h [`SW_READ_MAX_LENGTH],
    input  wire sw_pkg::col_t               i_col [`SW_READ_MAX_LENGTH],
    input  wire sw_pkg::row_t               i_sel_row,
    output sw_pkg::score_t                  o_row_score,
    output sw_pkg::col_t                    o_row_col
);
    import sw_pkg::*;

    score_t max_q [`SW_READ_MAX_LENGTH];
    col_t   col_q [`SW_READ_MAX_LENGTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < `SW_READ_MAX_LENGTH; r++) begin
                max_q[r] <= '0;
                col_q[r] <= '0;
            end
        end else if (i_clear) begin
            for (int r = 0; r < `SW_READ_MAX_LENGTH; r++) begin
                max_q[r] <= '0;
                col_q[r] <= '0;
            end
        end else begin
            // strictly greater keeps the leftmost column on ties
            for (int r = 0; r < `SW_READ_MAX_LENGTH; r++) begin
                if (i_cell_valid[r] && (i_h[r] > max_q[r])) begin
                    max_q[r] <= i_h[r];
                    col_q[r] <= i_col[r];
                end
            end
        end
    end

    assign o_row_score = max_q[i_sel_row];
    assign o_row_col   = col_q[i_sel_row];

endmodule

`default_nettype wire

//--- testbench/tb_sw_model.svh
// reference model: affine-gap smith-waterman matrices and first best cell
`ifndef TB_SW_MODEL_SVH
`define TB_SW_MODEL_SVH

function automatic int max_of3(input int a, input int b, input int c);
    int m;
    m = (a > b) ? a : b;
    return (m > c) ? m : c;
endfunction

function automatic void model_align(
    input  ref_seq_t  seq_ref,
    input  read_seq_t seq_read,
    input  int        ref_len,
    input  int        read_len,
    output int        best,
    output int        best_row,
    output int        best_col
);
    int    h   [`SW_READ_MAX_LENGTH+1][`SW_REF_MAX_LENGTH+1];
    int    ins [`SW_READ_MAX_LENGTH+1][`SW_REF_MAX_LENGTH+1];
    int    del [`SW_READ_MAX_LENGTH+1][`SW_REF_MAX_LENGTH+1];
    int    sub;
    base_t a;
    base_t b;
    best = 0;
    best_row = 0;
    best_col = 0;
    // row 0 and column 0 stand for cells outside the matrix
    for (int r = 0; r <= `SW_READ_MAX_LENGTH; r++) begin
        for (int c = 0; c <= `SW_REF_MAX_LENGTH; c++) begin
            h[r][c] = 0;
            ins[r][c] = 0;
            del[r][c] = 0;
        end
    end
    for (int r = 1; r <= read_len; r++) begin
        for (int c = 1; c <= ref_len; c++) begin
            b = seq_read[2*`SW_READ_MAX_LENGTH-2*r +: 2];
            a = seq_ref[2*`SW_REF_MAX_LENGTH-2*c +: 2];
            sub = (a == b) ? `SW_MATCH_SCORE : `SW_MISMATCH_SCORE;
            ins[r][c] = max_of3(0, h[r-1][c] + `SW_GAP_OPEN, ins[r-1][c] + `SW_GAP_EXTEND);
            del[r][c] = max_of3(0, h[r][c-1] + `SW_GAP_OPEN, del[r][c-1] + `SW_GAP_EXTEND);
            h[r][c] = max_of3(0, h[r-1][c-1] + sub, max_of3(0, ins[r][c], del[r][c]));
            if (h[r][c] > best) begin  // row-major scan keeps the first tie
                best = h[r][c];
                best_row = r - 1;
                best_col = c - 1;
            end
        end
    end
endfunction

`endif

//--- testbench/tb_sw_core.sv
// sw_core testbench with clock, reset, jobs, handshakes and result assertions
`timescale 1ns/1ps
`default_nettype none

`include "sw_config.svh"

module tb_sw_core;
    import sw_pkg::*;

    `include "tb_sw_model.svh"

    localparam int TIMEOUT_CYCLES = 200;

    logic      clk;
    logic      rst;
    logic      i_valid;
    logic      i_ready;
    ref_seq_t  i_sequence_ref;
    read_seq_t i_sequence_read;
    ref_len_t  i_ref_length;
    read_len_t i_read_length;
    logic      o_ready;
    logic      o_valid;
    score_t    o_alignment_score;
    row_t      o_row;
    col_t      o_column;

    score_t exp_score;
    row_t   exp_row;
    col_t   exp_col;
    int     value_errors;
    int     protocol_errors;
    bit     timed_out;
    logic   busy;   // between job acceptance and result handoff
    logic   fresh;  // nothing accepted since reset

    sw_core UUT (
        .clk(clk), .rst(rst), .i_valid(i_valid), .o_ready(o_ready),
        .i_sequence_ref(i_sequence_ref), .i_sequence_read(i_sequence_read),
        .i_ref_length(i_ref_length), .i_read_length(i_read_length), .i_ready(i_ready),
        .o_valid(o_valid), .o_alignment_score(o_alignment_score), .o_row(o_row),
        .o_column(o_column)
    );

    always #10 clk = ~clk;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            fresh <= 1'b1;
        end else if (i_valid && o_ready) begin
            busy  <= 1'b1;
            fresh <= 1'b0;
        end else if (o_valid && i_ready) begin
            busy  <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !busy |-> o_ready) else begin
        protocol_errors++;
        $display("ERR t=%0t o_ready exp=1 got=%0b", $time, o_ready);
    end
    assert property (@(posedge clk) disable iff (rst) busy |-> !o_ready) else begin
        protocol_errors++;
        $display("ERR t=%0t o_ready exp=0 got=%0b", $time, o_ready);
    end
    assert property (@(posedge clk) disable iff (rst) !busy |-> !o_valid) else begin
        protocol_errors++;
        $display("ERR t=%0t o_valid exp=0 got=%0b", $time, o_valid);
    end
    assert property (@(posedge clk) disable iff (rst) (o_valid && !i_ready) |=> o_valid)
    else begin
        protocol_errors++;
        $display("t=%0t result was withdrawn before the consumer took it", $time);
    end
    assert property (@(posedge clk) disable iff (rst) fresh |-> o_alignment_score == '0)
    else begin
        value_errors++;
        $display("ERR t=%0t o_alignment_score exp=0 got=%0d", $time, o_alignment_score);
    end
    // held results must keep matching for every cycle of o_valid
    assert property (@(posedge clk) disable iff (rst) o_valid |-> o_alignment_score == exp_score)
    else begin
        value_errors++;
        $display("ERR t=%0t o_alignment_score exp=%0d got=%0d", $time, exp_score,
                 o_alignment_score);
    end
    assert property (@(posedge clk) disable iff (rst) o_valid |-> o_row == exp_row) else begin
        value_errors++;
        $display("ERR t=%0t o_row exp=%0d got=%0d", $time, exp_row, o_row);
    end
    assert property (@(posedge clk) disable iff (rst) o_valid |-> o_column == exp_col) else begin
        value_errors++;
        $display("ERR t=%0t o_column exp=%0d got=%0d", $time, exp_col, o_column);
    end

    task automatic run_job(
        input ref_seq_t  seq_ref,
        input read_seq_t seq_read,
        input int        ref_len,
        input int        read_len,
        input int        hold
    );
        int score;
        int row;
        int col;
        int n;
        model_align(seq_ref, seq_read, ref_len, read_len, score, row, col);
        exp_score = score_t'(score);
        exp_row = row_t'(row);
        exp_col = col_t'(col);
        n = 0;
        while (!o_ready && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!o_ready) begin
            $display("timeout: o_ready stayed low for %0d cycles", TIMEOUT_CYCLES);
            timed_out = 1'b1;
            return;
        end
        i_valid = 1'b1;
        i_sequence_ref = seq_ref;
        i_sequence_read = seq_read;
        i_ref_length = ref_len_t'(ref_len);
        i_read_length = read_len_t'(read_len);
        @(posedge clk);
        #1;
        i_valid = 1'b0;
        i_sequence_ref = ref_seq_t'($urandom);  // engine works on its latched copy
        i_sequence_read = read_seq_t'($urandom);
        i_ref_length = ref_len_t'($urandom);
        i_read_length = read_len_t'($urandom);
        n = 0;
        while (!o_valid && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!o_valid) begin
            $display("timeout: no result within %0d cycles", TIMEOUT_CYCLES);
            timed_out = 1'b1;
            return;
        end
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        i_ready = 1'b1;
        @(posedge clk);
        #1;
        i_ready = 1'b0;
    endtask

    task automatic run_all();
        int ref_len;
        int read_len;
        // identical sequences along the full diagonal
        run_job({16'h1b6c, 16'h0000}, 16'h1b6c, 8, 8, 0);
        // no base in common
        if (!timed_out) run_job(32'h0000_0000, 16'h5555, 16, 8, 0);
        // read is a reference slice with one base removed
        if (!timed_out) run_job(32'h1b6c_e4d2, 16'hb738, 16, 7, 2);
        for (int j = 0; j < 20 && !timed_out; j++) begin
            ref_len = $urandom_range(1, `SW_REF_MAX_LENGTH);
            read_len = $urandom_range(1, `SW_READ_MAX_LENGTH);
            run_job(ref_seq_t'($urandom), read_seq_t'($urandom), ref_len, read_len,
                    $urandom_range(0, 5));
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        i_valid = 1'b0;
        i_ready = 1'b0;
        i_sequence_ref = '0;
        i_sequence_read = '0;
        i_ref_length = '0;
        i_read_length = '0;
        exp_score = '0;
        exp_row = '0;
        exp_col = '0;
        value_errors = 0;
        protocol_errors = 0;
        timed_out = 1'b0;
        void'($urandom(32'hea8c));
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        run_all();
        $display("errors: value=%0d protocol=%0d timeout=%0d", value_errors, protocol_errors,
                 timed_out);
        if (timed_out || value_errors != 0 || protocol_errors != 0) begin
            $display("RESULT: FAIL");
        end else begin
            $display("RESULT: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire
